// File: filelist.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/alu_pkg.sv
hdl/baud_rate_gen.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/alu.sv
hdl/alu_interface.sv
hdl/uart_alu_top.sv
tb/uart_alu_tb.sv

// File: hdl/alu.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module alu
(
	input  logic [`NBIT_DATA-1:0] operand_a,
	input  logic [`NBIT_DATA-1:0] operand_b,
	input  alu_pkg::opcode_t      opcode,
	output logic [`NBIT_DATA-1:0] result
);

	import alu_pkg::*;

	localparam int shamt_w = $clog2(`NBIT_DATA);

	logic [shamt_w-1:0] shamt; // low bits of b set the shift distance

	assign shamt = operand_b[shamt_w-1:0];

	always_comb
	begin
		case (opcode)
			op_add: result = operand_a + operand_b; // wraps modulo 256
			op_sub: result = operand_a - operand_b;
			op_and: result = operand_a & operand_b;
			op_or:  result = operand_a | operand_b;
			op_xor: result = operand_a ^ operand_b;
			op_nor: result = ~(operand_a | operand_b);
			op_sra: result = $unsigned($signed(operand_a) >>> shamt); // sign fill
			op_srl: result = operand_a >> shamt; // zero fill
			default: result = '0; // undefined opcode
		endcase
	end

endmodule

// File: hdl/alu_interface.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module alu_interface
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  rx_done,
	input  logic [`NBIT_DATA-1:0] rx_data,
	input  logic                  tx_busy,
	input  logic [`NBIT_DATA-1:0] result,
	output logic [`NBIT_DATA-1:0] operand_a,
	output logic [`NBIT_DATA-1:0] operand_b,
	output alu_pkg::opcode_t      opcode,
	output logic                  tx_start,
	output logic [`NBIT_DATA-1:0] tx_data
);

	import alu_pkg::*;

	logic [1:0] byte_cnt;     // 0 = operand a, 1 = operand b, 2 = opcode
	logic       result_valid; // alu result settles this clk
	logic       tx_pending;   // result held, waiting for a free transmitter

	//////////////////////////////////////////////////
	// byte sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			byte_cnt     <= 2'd0;
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= 1'b0; // one clk strobe
			if (rx_done)
			begin
				if (byte_cnt == 2'd2)
				begin
					byte_cnt     <= 2'd0; // next byte opens a new triple
					result_valid <= 1'b1;
				end
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	// operand and opcode capture
	always_ff @(posedge clk)
	begin
		if (rx_done)
		begin
			case (byte_cnt)
				2'd0: operand_a <= rx_data;
				2'd1: operand_b <= rx_data;
				default: opcode <= opcode_t'(rx_data[5:0]); // upper bits ignored
			endcase
		end
	end

	//////////////////////////////////////////////////
	// result hand-off to the transmitter
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			tx_start   <= 1'b0;
			tx_pending <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0; // single clk pulse
			if (result_valid)
			begin
				if (tx_busy)
					tx_pending <= 1'b1; // hold until the line frees up
				else
					tx_start <= 1'b1;
			end
			else if (tx_pending && !tx_busy)
			begin
				tx_start   <= 1'b1;
				tx_pending <= 1'b0;
			end
		end
	end

	// result register, stays put while pending
	always_ff @(posedge clk)
	begin
		if (result_valid)
			tx_data <= result;
	end

endmodule

// File: hdl/alu_pkg.sv
package alu_pkg;

	// alu operation codes, taken from the low 6 bits of the opcode byte
	typedef enum logic [5:0]
	{
		op_add = 6'b100000, // a + b
		op_sub = 6'b100010, // a - b
		op_and = 6'b100100, // bitwise and
		op_or  = 6'b100101, // bitwise or
		op_xor = 6'b100110, // bitwise xor
		op_nor = 6'b100111, // bitwise nor
		op_sra = 6'b000011, // arithmetic shift right
		op_srl = 6'b000010  // logical shift right
	} opcode_t;

endpackage

// File: hdl/baud_rate_gen.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module baud_rate_gen
(
	input  logic clk,
	input  logic reset,
	output logic tick
);

	localparam int cnt_w = $clog2(`TICK_DIVISOR);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`TICK_DIVISOR - 1); // wrap value

	logic [cnt_w-1:0] cnt; // free-running divider

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt  <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= (cnt == cnt_last); // one clk pulse at wrap
			if (cnt == cnt_last)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

// File: hdl/uart_alu_top.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_alu_top
(
	input  logic clk,
	input  logic reset,
	input  logic rx,
	output logic tx
);

	import alu_pkg::*;

	logic                  tick;      // shared oversampling base
	logic                  rx_done;
	logic [`NBIT_DATA-1:0] rx_data;
	logic [`NBIT_DATA-1:0] operand_a;
	logic [`NBIT_DATA-1:0] operand_b;
	opcode_t               opcode;
	logic [`NBIT_DATA-1:0] result;
	logic                  tx_start;
	logic [`NBIT_DATA-1:0] tx_data;
	logic                  tx_busy;

	baud_rate_gen i_baud_rate_gen
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uart_rx i_uart_rx
	(
		.clk     (clk),
		.reset   (reset),
		.tick    (tick),
		.rx      (rx),
		.rx_done (rx_done),
		.rx_data (rx_data)
	);

	alu_interface i_alu_interface
	(
		.clk       (clk),
		.reset     (reset),
		.rx_done   (rx_done),
		.rx_data   (rx_data),
		.tx_busy   (tx_busy),
		.result    (result),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.opcode    (opcode),
		.tx_start  (tx_start),
		.tx_data   (tx_data)
	);

	alu i_alu
	(
		.operand_a (operand_a),
		.operand_b (operand_b),
		.opcode    (opcode),
		.result    (result)
	);

	uart_tx i_uart_tx
	(
		.clk      (clk),
		.reset    (reset),
		.tick     (tick),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx_busy  (tx_busy),
		.tx       (tx)
	);

endmodule

// File: hdl/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

//////////////////////////////////////////////////
// serial frame format
//////////////////////////////////////////////////

// data bits per frame, lsb first on the line
`define NBIT_DATA 8

// oversampling ticks per bit
`define NUM_TICKS 16

//////////////////////////////////////////////////
// time base
//////////////////////////////////////////////////

// clk cycles per tick, so one bit = NUM_TICKS * TICK_DIVISOR clocks
`define TICK_DIVISOR 4

`endif

// File: hdl/uart_pkg.sv
package uart_pkg;

	// receiver fsm
	typedef enum logic [1:0]
	{
		rx_st_idle  = 2'b00, // waiting for low on the line
		rx_st_start = 2'b01, // moving to mid start bit
		rx_st_data  = 2'b10, // shifting data bits in
		rx_st_stop  = 2'b11  // waiting out the stop bit
	} rx_state_t;

	// transmitter fsm
	typedef enum logic [1:0]
	{
		tx_st_idle  = 2'b00, // line held high
		tx_st_start = 2'b01, // driving the start bit
		tx_st_data  = 2'b10, // driving data bits
		tx_st_stop  = 2'b11  // driving the stop bit
	} tx_state_t;

endpackage

// File: hdl/uart_rx.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_rx
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  tick,
	input  logic                  rx,
	output logic                  rx_done,
	output logic [`NBIT_DATA-1:0] rx_data
);

	import uart_pkg::*;

	localparam int tick_w = $clog2(`NUM_TICKS);
	localparam int bit_w  = $clog2(`NBIT_DATA);
	localparam logic [tick_w-1:0] tick_half = tick_w'(`NUM_TICKS / 2 - 1); // mid start bit
	localparam logic [tick_w-1:0] tick_last = tick_w'(`NUM_TICKS - 1);     // one full bit
	localparam logic [bit_w-1:0]  bit_last  = bit_w'(`NBIT_DATA - 1);

	rx_state_t             state;
	logic [tick_w-1:0]     tick_cnt;  // ticks within the current bit
	logic [bit_w-1:0]      bit_cnt;   // data bits received so far
	logic [`NBIT_DATA-1:0] shift_reg; // assembling byte
	logic                  bit_end;   // tick that lands mid-bit

	assign bit_end = tick && (tick_cnt == tick_last);

	//////////////////////////////////////////////////
	// control fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= rx_st_idle;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			rx_done  <= 1'b0;
		end
		else
		begin
			rx_done <= 1'b0; // single clk pulse
			if (tick)
			begin
				case (state)
					rx_st_idle:
					begin
						if (!rx) // start bit seen
						begin
							state    <= rx_st_start;
							tick_cnt <= '0;
						end
					end
					rx_st_start:
					begin
						if (tick_cnt == tick_half) // centered on start bit
						begin
							state    <= rx_st_data;
							tick_cnt <= '0;
							bit_cnt  <= '0;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					rx_st_data:
					begin
						if (tick_cnt == tick_last) // mid data bit
						begin
							tick_cnt <= '0;
							if (bit_cnt == bit_last)
								state <= rx_st_stop;
							else
								bit_cnt <= bit_cnt + 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					rx_st_stop:
					begin
						if (tick_cnt == tick_last) // mid stop bit, level not checked
						begin
							state    <= rx_st_idle;
							tick_cnt <= '0;
							bit_cnt  <= '0;
							rx_done  <= 1'b1;
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
					default:
					begin
						state    <= rx_st_idle;
						tick_cnt <= '0;
						bit_cnt  <= '0;
					end
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// data path
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (bit_end && state == rx_st_data)
			shift_reg <= {rx, shift_reg[`NBIT_DATA-1:1]}; // in from the top, lsb ends at bit 0
		if (bit_end && state == rx_st_stop)
			rx_data <= shift_reg; // held until the next frame completes
	end

endmodule

// File: hdl/uart_tx.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_tx
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  tick,
	input  logic                  tx_start,
	input  logic [`NBIT_DATA-1:0] tx_data,
	output logic                  tx_busy,
	output logic                  tx
);

	import uart_pkg::*;

	localparam int tick_w = $clog2(`NUM_TICKS);
	localparam int bit_w  = $clog2(`NBIT_DATA);
	localparam logic [tick_w-1:0] tick_last = tick_w'(`NUM_TICKS - 1); // end of one bit
	localparam logic [bit_w-1:0]  bit_last  = bit_w'(`NBIT_DATA - 1);

	tx_state_t             state;
	logic [tick_w-1:0]     tick_cnt;  // ticks within the current bit
	logic [bit_w-1:0]      bit_cnt;   // data bits sent so far
	logic [`NBIT_DATA-1:0] shift_reg; // outgoing byte, lsb at bit 0

	//////////////////////////////////////////////////
	// control fsm and line driver
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= tx_st_idle;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx_busy  <= 1'b0;
			tx       <= 1'b1; // line rests high
		end
		else
		begin
			case (state)
				tx_st_idle:
				begin
					if (tx_start)
					begin
						state    <= tx_st_start;
						tick_cnt <= '0;
						tx_busy  <= 1'b1;
						tx       <= 1'b0; // start bit
					end
				end
				tx_st_start:
				begin
					if (tick)
					begin
						if (tick_cnt == tick_last)
						begin
							state    <= tx_st_data;
							tick_cnt <= '0;
							bit_cnt  <= '0;
							tx       <= shift_reg[0]; // first data bit
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				tx_st_data:
				begin
					if (tick)
					begin
						if (tick_cnt == tick_last)
						begin
							tick_cnt <= '0;
							if (bit_cnt == bit_last)
							begin
								state <= tx_st_stop;
								tx    <= 1'b1; // stop bit
							end
							else
							begin
								bit_cnt <= bit_cnt + 1'b1;
								tx      <= shift_reg[1]; // next bit before the shift lands
							end
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				tx_st_stop:
				begin
					if (tick)
					begin
						if (tick_cnt == tick_last)
						begin
							state    <= tx_st_idle;
							tick_cnt <= '0;
							tx_busy  <= 1'b0; // frame complete
						end
						else
							tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default:
				begin
					state   <= tx_st_idle;
					tx_busy <= 1'b0;
					tx      <= 1'b1;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// shift register
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (state == tx_st_idle && tx_start)
			shift_reg <= tx_data; // capture on the start strobe
		else if (state == tx_st_data && tick && tick_cnt == tick_last)
			shift_reg <= shift_reg >> 1; // advance one bit
	end

endmodule

// File: tb/uart_alu_tb.sv
`timescale 1ns/10ps
`include "uart_config.svh"

module uart_alu_tb;

	import alu_pkg::*;

	localparam int bit_clks    = `NUM_TICKS * `TICK_DIVISOR; // clocks per serial bit
	localparam int num_tests   = 50;                         // 9 edge, 40 random, 1 undefined
	localparam int cycle_limit = num_tests * 4 * 640 * 5 / 4; // 4 frames per test plus 25% margin

	logic clk;
	logic reset;
	logic rx;
	logic tx;

	logic [15:0] lfsr_state;     // galois lfsr for operands
	int          cycles;         // run length so far
	int          value_errors;   // wrong result bytes
	int          line_errors;    // framing and line faults
	int          frames_sent;    // triples whose opcode reached its stop bit
	int          frames_started; // start bits seen on tx
	int          frames_done;    // frames fully sampled
	logic [7:0]  exp_q[$];       // expected results, oldest first
	string       name_q[$];      // matching test names

	uart_alu_top i_uart_alu_top
	(
		.clk   (clk),
		.reset (reset),
		.rx    (rx),
		.tx    (tx)
	);

	always #20 clk = ~clk; // 40 ns period

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	function logic lfsr_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 16'hB400; // taps 16,14,13,11
		return out;
	endfunction

	function automatic logic [7:0] random_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_bit()}; // one step per bit
		return v;
	endfunction

	function automatic opcode_t op_from_index(input logic [2:0] idx);
		case (idx)
			3'd0: return op_add;
			3'd1: return op_sub;
			3'd2: return op_and;
			3'd3: return op_or;
			3'd4: return op_xor;
			3'd5: return op_nor;
			3'd6: return op_sra;
			default: return op_srl;
		endcase
	endfunction

	// expected byte for one triple
	function automatic logic [7:0] ref_result(input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] op_byte);
		logic [5:0]  code;
		logic [2:0]  sh;
		logic [15:0] ext;
		code = op_byte[5:0]; // top two bits dont matter
		sh   = b[2:0];
		ext  = {{8{a[7]}}, a}; // sign extended copy for sra
		case (code)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or:  return a | b;
			op_xor: return a ^ b;
			op_nor: return ~(a | b);
			op_sra: return 8'(ext >> sh);
			op_srl: return a >> sh;
			default: return 8'h00;
		endcase
	endfunction

	// one frame on rx driven on falling edges
	task automatic send_byte(input logic [7:0] value, input bit closes_triple);
		@(negedge clk);
		rx = 1'b0; // start bit
		repeat (bit_clks) @(negedge clk);
		for (int i = 0; i < 8; i++)
		begin
			rx = value[i]; // lsb first
			repeat (bit_clks) @(negedge clk);
		end
		rx = 1'b1; // stop bit
		if (closes_triple)
			frames_sent++; // result may start from mid stop bit on
		repeat (bit_clks - 1) @(negedge clk);
	endtask

	task automatic send_triple(input string name, input logic [7:0] a, input logic [7:0] b,
		input logic [7:0] op_byte);
		exp_q.push_back(ref_result(a, b, op_byte));
		name_q.push_back(name);
		send_byte(a, 1'b0);
		send_byte(b, 1'b0);
		send_byte(op_byte, 1'b1);
	endtask

	//////////////////////////////////////////////////
	// tx monitor
	//////////////////////////////////////////////////

	// entered on the first falling edge that sees tx low
	task automatic receive_frame(output logic [7:0] data, output logic start_lvl,
		output logic stop_lvl);
		repeat (bit_clks / 2 - 1) @(negedge clk);
		start_lvl = tx; // mid start bit
		for (int i = 0; i < 8; i++)
		begin
			repeat (bit_clks) @(negedge clk);
			data[i] = tx;
		end
		repeat (bit_clks) @(negedge clk);
		stop_lvl = tx; // mid stop bit
	endtask

	initial
	begin
		logic [7:0] data;
		logic       start_lvl;
		logic       stop_lvl;
		logic [7:0] exp;
		string      name;
		@(negedge clk);
		wait (!reset);
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				frames_started++;
				receive_frame(data, start_lvl, stop_lvl);
				frames_done++;
				assert (start_lvl === 1'b0)
				else
				begin
					line_errors++;
					$display("start bit on tx did not stay low to mid bit");
				end
				assert (stop_lvl === 1'b1)
				else
				begin
					line_errors++;
					$display("stop bit on tx was not high");
				end
				if (exp_q.size() > 0)
				begin
					exp  = exp_q.pop_front();
					name = name_q.pop_front();
					assert (data === exp)
					else
					begin
						value_errors++;
						$display("mismatch %s expected %02h actual %02h", name, exp, data);
					end
				end
				else
				begin
					line_errors++;
					$display("frame on tx with no result expected");
				end
			end
		end
	end

	// tx may only fall when a triple is owed a result
	// the monitor has already counted this start bit by the sampling edge
	assert property (@(posedge clk) disable iff (reset)
		$fell(tx) |-> (frames_sent >= frames_started))
	else
	begin
		line_errors++;
		$display("start bit on tx before a full triple was sent");
	end

	//////////////////////////////////////////////////
	// timeout
	//////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			$display("timeout after %0d cycles, results still outstanding", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		clk            = 1'b0;
		reset          = 1'b1;
		rx             = 1'b1; // idle line
		lfsr_state     = 16'd9563;
		cycles         = 0;
		value_errors   = 0;
		line_errors    = 0;
		frames_sent    = 0;
		frames_started = 0;
		frames_done    = 0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (tx === 1'b1)
		else
		begin
			line_errors++;
			$display("tx not high after reset");
		end
		repeat (2 * bit_clks) @(negedge clk); // quiet line first

		// edge operands with one per opcode plus a zero shift
		send_triple("edge_add", 8'd255, 8'd128, {2'b00, op_add});
		send_triple("edge_sub", 8'd0, 8'd255, {2'b00, op_sub});
		send_triple("edge_and", 8'd128, 8'd127, {2'b00, op_and});
		send_triple("edge_or", 8'd128, 8'd127, {2'b00, op_or});
		send_triple("edge_xor", 8'd255, 8'd127, {2'b00, op_xor});
		send_triple("edge_nor", 8'd0, 8'd128, {2'b00, op_nor});
		send_triple("edge_sra", 8'd128, 8'd7, {2'b00, op_sra});
		send_triple("edge_srl", 8'd255, 8'd7, {2'b00, op_srl});
		send_triple("edge_sra_zero", 8'd127, 8'd0, {2'b00, op_sra});

		// back to back random triples with random upper opcode bits
		for (int i = 0; i < 40; i++)
		begin
			logic [7:0] a;
			logic [7:0] b;
			logic [2:0] idx;
			logic [1:0] hi;
			a   = random_bits(8);
			b   = random_bits(8);
			idx = 3'(random_bits(3));
			hi  = 2'(random_bits(2));
			send_triple($sformatf("rand_%0d", i), a, b, {hi, op_from_index(idx)});
		end

		send_triple("undefined_op", 8'd77, 8'd33, 8'hFF); // 111111 decodes to nothing

		wait (frames_done == frames_sent);
		repeat (2 * bit_clks) @(negedge clk); // line must stay quiet
		assert (frames_started == frames_sent && exp_q.size() == 0)
		else
		begin
			line_errors++;
			$display("result frame count %0d does not match %0d triples",
				frames_started, frames_sent);
		end

		$display("errors: %0d value, %0d line", value_errors, line_errors);
		if (value_errors == 0 && line_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
